// File: hw/rv64_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_alu import rv64_pkg::*; (
    input  xlen_t    a_i,
    input  xlen_t    b_i,
    input  alu_op_e  alu_op_i,
    input  ls_type_t funct3_i,       // branch condition select
    output xlen_t    result_o,
    output logic     branch_taken_o
);

    logic [5:0] shamt;
    logic       eq;
    logic       lt;     // signed
    logic       ltu;    // unsigned

    assign shamt = b_i[5:0];   // low six bits only
    assign eq    = (a_i == b_i);
    assign lt    = ($signed(a_i) < $signed(b_i));
    assign ltu   = (a_i < b_i);

    always_comb begin
        case (alu_op_i)
            alu_add:  result_o = a_i + b_i;
            alu_sub:  result_o = a_i - b_i;
            alu_sll:  result_o = a_i << shamt;
            alu_slt:  result_o = {63'b0, lt};
            alu_sltu: result_o = {63'b0, ltu};
            alu_xor:  result_o = a_i ^ b_i;
            alu_srl:  result_o = a_i >> shamt;
            alu_sra:  result_o = xlen_t'($signed(a_i) >>> shamt);  // sign fill
            alu_or:   result_o = a_i | b_i;
            alu_and:  result_o = a_i & b_i;
            default:  result_o = '0;
        endcase
    end

    // compare rs1 against rs2, only meaningful for branches
    always_comb begin
        case (funct3_i)
            F3_BEQ:  branch_taken_o = eq;
            F3_BNE:  branch_taken_o = !eq;
            F3_BLT:  branch_taken_o = lt;
            F3_BGE:  branch_taken_o = !lt;
            F3_BLTU: branch_taken_o = ltu;
            F3_BGEU: branch_taken_o = !ltu;
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rv64_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_core import rv64_pkg::*; #(
    parameter xlen_t RESET_PC = 64'h0000_0000_8000_0000,
    parameter int    NUM_REGS = 32
) (
    input  logic     clk,
    input  logic     reset,
    input  inst_t    instruction_i,     // word at pc_o, same cycle
    output xlen_t    pc_o,
    output xlen_t    bus_address_o,
    output xlen_t    bus_write_data_o,
    output logic     bus_write_enable_o,
    output logic     bus_read_enable_o,
    output ls_type_t bus_ls_type_o,
    input  logic     bus_read_done_i,
    input  logic     bus_write_done_i,
    input  xlen_t    bus_read_data_i
);

    inst_t     ir;
    logic      bubble;      // ir holds a flushed slot
    logic      active;
    op_class_e op_class;
    alu_op_e   alu_op;
    xlen_t     imm;
    logic      use_imm;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    ls_type_t  funct3;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     alu_b;
    xlen_t     alu_result;
    logic      branch_taken;
    logic      stall;
    logic      load_wr;
    xlen_t     load_data;
    xlen_t     ir_pc;       // address of the word in ir
    xlen_t     pc_rel;
    logic      taken;
    xlen_t     target;
    logic      wb_en;
    xlen_t     wb_data;

    assign active = !bubble;
    assign ir_pc  = pc_o - 64'd4;   // pc runs one word ahead
    assign pc_rel = ir_pc + imm;    // auipc, jal, branch target
    assign alu_b  = use_imm ? imm : rs2_data;

    assign taken  = active && ((op_class == op_jal) || (op_class == op_jalr) ||
                               (op_class == op_branch && branch_taken));
    assign target = (op_class == op_jalr) ? {alu_result[63:1], 1'b0} : pc_rel;

    // write-back select, loads come in later through load_wr
    always_comb begin
        wb_en   = 1'b0;
        wb_data = alu_result;
        if (load_wr) begin
            wb_en   = 1'b1;
            wb_data = load_data;
        end else if (active) begin
            case (op_class)
                op_lui:          begin wb_en = 1'b1; wb_data = imm;        end
                op_auipc:        begin wb_en = 1'b1; wb_data = pc_rel;     end
                op_imm, op_reg:  begin wb_en = 1'b1; wb_data = alu_result; end
                op_jal, op_jalr: begin wb_en = 1'b1; wb_data = pc_o;       end  // link
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o   <= RESET_PC;
            ir     <= NOP_INST;
            bubble <= 1'b0;
        end else if (!stall) begin      // memory access freezes fetch
            if (taken) begin
                pc_o   <= target;
                ir     <= NOP_INST;     // drop the word behind the jump
                bubble <= 1'b1;
            end else begin
                pc_o   <= pc_o + 64'd4;
                ir     <= instruction_i;
                bubble <= 1'b0;
            end
        end
    end

    rv64_decode u_decode (
        .ir_i      (ir),
        .class_o   (op_class),
        .alu_op_o  (alu_op),
        .imm_o     (imm),
        .use_imm_o (use_imm),
        .rd_o      (rd),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .funct3_o  (funct3)
    );

    rv64_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .wr_en_i    (wb_en),
        .wr_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv64_alu u_alu (
        .a_i            (rs1_data),
        .b_i            (alu_b),
        .alu_op_i       (alu_op),
        .funct3_i       (funct3),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    rv64_lsu u_lsu (
        .clk                (clk),
        .reset              (reset),
        .class_i            (op_class),
        .active_i           (active),
        .base_i             (rs1_data),
        .offset_i           (imm),
        .store_data_i       (rs2_data),
        .funct3_i           (funct3),
        .stall_o            (stall),
        .load_wr_o          (load_wr),
        .load_data_o        (load_data),
        .bus_address_o      (bus_address_o),
        .bus_write_data_o   (bus_write_data_o),
        .bus_write_enable_o (bus_write_enable_o),
        .bus_read_enable_o  (bus_read_enable_o),
        .bus_ls_type_o      (bus_ls_type_o),
        .bus_read_done_i    (bus_read_done_i),
        .bus_write_done_i   (bus_write_done_i),
        .bus_read_data_i    (bus_read_data_i)
    );

endmodule

`default_nettype wire

// File: hw/rv64_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_decode import rv64_pkg::*; (
    input  inst_t     ir_i,
    output op_class_e class_o,
    output alu_op_e   alu_op_o,
    output xlen_t     imm_o,
    output logic      use_imm_o,   // b operand is the immediate
    output reg_idx_t  rd_o,
    output reg_idx_t  rs1_o,
    output reg_idx_t  rs2_o,
    output ls_type_t  funct3_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    xlen_t      imm_u;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_j;
    xlen_t      imm_b;
    logic       shift_ok;   // legal shift-immediate function bits
    logic       reg_ok;     // legal funct7 for register ops

    assign opcode   = ir_i[6:0];
    assign funct7   = ir_i[31:25];
    assign rd_o     = ir_i[11:7];
    assign rs1_o    = ir_i[19:15];
    assign rs2_o    = ir_i[24:20];
    assign funct3_o = ir_i[14:12];

    assign imm_u = {{32{ir_i[31]}}, ir_i[31:12], 12'b0};
    assign imm_i = {{52{ir_i[31]}}, ir_i[31:20]};
    assign imm_s = {{52{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_j = {{44{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
    assign imm_b = {{52{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};

    // rv64 shamt takes 6 bits, funct6 sits in ir[31:26]
    assign shift_ok = (ir_i[31:26] == F7_BASE[6:1]) ||
                      (ir_i[31:26] == F7_ALT[6:1] && funct3_o == F3_SRL_SRA);
    assign reg_ok   = (funct7 == F7_BASE) ||
                      (funct7 == F7_ALT &&
                       (funct3_o == F3_ADD_SUB || funct3_o == F3_SRL_SRA));

    always_comb begin
        class_o = op_illegal;   // anything else runs as a nop
        case (opcode)
            OPC_LUI:    class_o = op_lui;
            OPC_AUIPC:  class_o = op_auipc;
            OPC_JAL:    class_o = op_jal;
            OPC_JALR:   if (funct3_o == 3'b000) class_o = op_jalr;
            OPC_BRANCH: if (funct3_o[2:1] != 2'b01) class_o = op_branch;  // no 010/011
            OPC_LOAD:   if (funct3_o != 3'b111) class_o = op_load;
            OPC_STORE:  if (!funct3_o[2]) class_o = op_store;           // sb..sd only
            OPC_IMM:    if (funct3_o[1:0] != 2'b01 || shift_ok) class_o = op_imm;
            OPC_REG:    if (reg_ok) class_o = op_reg;
            default: ;
        endcase
    end

    always_comb begin
        case (funct3_o)
            F3_ADD_SUB: alu_op_o = (class_o == op_reg && ir_i[30]) ? alu_sub : alu_add;
            F3_SLL:     alu_op_o = alu_sll;
            F3_SLT:     alu_op_o = alu_slt;
            F3_SLTU:    alu_op_o = alu_sltu;
            F3_XOR:     alu_op_o = alu_xor;
            F3_SRL_SRA: alu_op_o = ir_i[30] ? alu_sra : alu_srl;
            F3_OR:      alu_op_o = alu_or;
            F3_AND:     alu_op_o = alu_and;
            default:    alu_op_o = alu_add;
        endcase
        // jalr target and everything else wants a plain sum
        if (class_o != op_imm && class_o != op_reg) alu_op_o = alu_add;
    end

    always_comb begin
        case (class_o)
            op_lui, op_auipc: imm_o = imm_u;
            op_store:         imm_o = imm_s;
            op_jal:           imm_o = imm_j;
            op_branch:        imm_o = imm_b;
            default:          imm_o = imm_i;   // op-imm, loads, jalr
        endcase
    end

    assign use_imm_o = (class_o == op_imm) || (class_o == op_load) ||
                       (class_o == op_store) || (class_o == op_jalr);

endmodule

`default_nettype wire

// File: hw/rv64_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_lsu import rv64_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  op_class_e class_i,
    input  logic      active_i,       // low during a bubble
    input  xlen_t     base_i,         // rs1
    input  xlen_t     offset_i,       // I or S immediate
    input  xlen_t     store_data_i,   // rs2
    input  ls_type_t  funct3_i,
    output logic      stall_o,
    output logic      load_wr_o,
    output xlen_t     load_data_o,
    output xlen_t     bus_address_o,
    output xlen_t     bus_write_data_o,
    output logic      bus_write_enable_o,
    output logic      bus_read_enable_o,
    output ls_type_t  bus_ls_type_o,
    input  logic      bus_read_done_i,
    input  logic      bus_write_done_i,
    input  xlen_t     bus_read_data_i
);

    typedef enum logic {st_idle, st_wait} lsu_state_e;

    lsu_state_e state;
    logic       is_load;
    logic       is_mem;
    logic       start;    // launch this cycle
    logic       done;     // matching done seen while waiting
    xlen_t      wdata;

    // ir is frozen while we wait, so the class still tells read from write
    assign is_load   = (class_i == op_load);
    assign is_mem    = is_load || (class_i == op_store);
    assign start     = (state == st_idle) && active_i && is_mem;
    assign done      = (state == st_wait) && (is_load ? bus_read_done_i : bus_write_done_i);
    assign stall_o   = start || (state == st_wait && !done);
    assign load_wr_o = done && is_load;   // rd written at this edge

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state              <= st_idle;
            bus_read_enable_o  <= 1'b0;
            bus_write_enable_o <= 1'b0;
        end else begin
            bus_read_enable_o  <= start && is_load;    // single pulse
            bus_write_enable_o <= start && !is_load;
            case (state)
                st_idle: if (start) state <= st_wait;
                st_wait: if (done) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // bus fields held until the next launch
    always_ff @(posedge clk) begin
        if (start) begin
            bus_address_o    <= base_i + offset_i;
            bus_write_data_o <= wdata;
            bus_ls_type_o    <= funct3_i;
        end
    end

    always_comb begin
        case (funct3_i)
            LS_B:    wdata = {56'b0, store_data_i[7:0]};
            LS_H:    wdata = {48'b0, store_data_i[15:0]};
            LS_W:    wdata = {32'b0, store_data_i[31:0]};
            default: wdata = store_data_i;    // sd
        endcase
    end

    // sign or zero extension by the registered type
    always_comb begin
        case (bus_ls_type_o)
            LS_B:    load_data_o = {{56{bus_read_data_i[7]}}, bus_read_data_i[7:0]};
            LS_H:    load_data_o = {{48{bus_read_data_i[15]}}, bus_read_data_i[15:0]};
            LS_W:    load_data_o = {{32{bus_read_data_i[31]}}, bus_read_data_i[31:0]};
            LS_BU:   load_data_o = {56'b0, bus_read_data_i[7:0]};
            LS_HU:   load_data_o = {48'b0, bus_read_data_i[15:0]};
            LS_WU:   load_data_o = {32'b0, bus_read_data_i[31:0]};
            LS_D:    load_data_o = bus_read_data_i;
            default: load_data_o = bus_read_data_i;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rv64_pkg.sv
`default_nettype none

package rv64_pkg;

    typedef logic [63:0] xlen_t;    // architectural word
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  ls_type_t; // funct3 of the load/store

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    // integer funct3
    localparam ls_type_t F3_ADD_SUB = 3'b000;
    localparam ls_type_t F3_SLL     = 3'b001;
    localparam ls_type_t F3_SLT     = 3'b010;
    localparam ls_type_t F3_SLTU    = 3'b011;
    localparam ls_type_t F3_XOR     = 3'b100;
    localparam ls_type_t F3_SRL_SRA = 3'b101;
    localparam ls_type_t F3_OR      = 3'b110;
    localparam ls_type_t F3_AND     = 3'b111;

    // branch funct3
    localparam ls_type_t F3_BEQ  = 3'b000;
    localparam ls_type_t F3_BNE  = 3'b001;
    localparam ls_type_t F3_BLT  = 3'b100;
    localparam ls_type_t F3_BGE  = 3'b101;
    localparam ls_type_t F3_BLTU = 3'b110;
    localparam ls_type_t F3_BGEU = 3'b111;

    // access width / signedness, same code as funct3
    localparam ls_type_t LS_B  = 3'b000;
    localparam ls_type_t LS_H  = 3'b001;
    localparam ls_type_t LS_W  = 3'b010;
    localparam ls_type_t LS_D  = 3'b011;
    localparam ls_type_t LS_BU = 3'b100;
    localparam ls_type_t LS_HU = 3'b101;
    localparam ls_type_t LS_WU = 3'b110;

    localparam inst_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [3:0] {
        op_lui, op_auipc, op_imm, op_reg, op_load,
        op_store, op_jal, op_jalr, op_branch, op_illegal
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

endpackage

`default_nettype wire

// File: hw/rv64_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_regfile import rv64_pkg::*; #(
    parameter int NUM_REGS = 32     // 32, or 16 for a reduced file
) (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t rd_i,
    input  logic     wr_en_i,
    input  xlen_t    wr_data_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o
);

    localparam int IDX_W = $clog2(NUM_REGS);

    xlen_t            regs [NUM_REGS];
    logic [IDX_W-1:0] wr_idx;

    assign wr_idx = rd_i[IDX_W-1:0];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_idx != '0) begin   // x0 never written
            regs[wr_idx] <= wr_data_i;
        end
    end

    // combinational reads, x0 stays zero from reset
    assign rs1_data_o = regs[rs1_i[IDX_W-1:0]];
    assign rs2_data_o = regs[rs2_i[IDX_W-1:0]];

endmodule

`default_nettype wire

// File: rv64_core.f
hw/rv64_pkg.sv
hw/rv64_decode.sv
hw/rv64_alu.sv
hw/rv64_regfile.sv
hw/rv64_lsu.sv
hw/rv64_core.sv
testbench/rv64_core_tb.sv

// File: testbench/rv64_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_core_tb import rv64_pkg::*; ();

    localparam xlen_t RESET_PC    = 64'h0000_0000_8000_0000;
    localparam int    CLK_PERIOD  = 20;
    localparam xlen_t OPA_ADDR    = 64'h100;    // ld x1 source
    localparam xlen_t OPB_ADDR    = 64'h108;    // ld x2 source
    localparam xlen_t STORE_ADDR  = 64'h200;    // slot 3 result store
    localparam xlen_t TARGET_ADDR = 64'h210;    // jump target store in slot 5

    // program layout kinds
    localparam logic [1:0] K_PLAIN  = 2'd0;   // rd stored by slot 3
    localparam logic [1:0] K_STORE  = 2'd1;
    localparam logic [1:0] K_BRANCH = 2'd2;
    localparam logic [1:0] K_JUMP   = 2'd3;

    typedef struct packed {
        logic [1:0] kind;
        inst_t      inst;
        xlen_t      op_a;       // returned for ld x1
        xlen_t      op_b;       // returned for ld x2
        xlen_t      imm;
        xlen_t      exp_addr;
        xlen_t      exp_data;
        ls_type_t   exp_type;
    } row_t;

    logic     clk;
    logic     reset;
    inst_t    instruction;
    xlen_t    pc;
    xlen_t    bus_address;
    xlen_t    bus_write_data;
    logic     bus_write_enable;
    logic     bus_read_enable;
    ls_type_t bus_ls_type;
    logic     bus_read_done;
    logic     bus_write_done;
    xlen_t    bus_read_data;

    inst_t    imem [0:63];
    xlen_t    pc_off;
    row_t     rows [$];
    xlen_t    wr_addr_q [$];    // every bus write seen
    xlen_t    wr_data_q [$];
    ls_type_t wr_type_q [$];
    xlen_t    cur_a;
    xlen_t    cur_b;
    integer   seed = 23;
    int       errors = 0;
    int       tests_failed = 0;
    logic     row_ok;
    logic     table_ready = 1'b0;

    rv64_core #(
        .RESET_PC (RESET_PC),
        .NUM_REGS (32)
    ) u_dut (
        .clk                (clk),
        .reset              (reset),
        .instruction_i      (instruction),
        .pc_o               (pc),
        .bus_address_o      (bus_address),
        .bus_write_data_o   (bus_write_data),
        .bus_write_enable_o (bus_write_enable),
        .bus_read_enable_o  (bus_read_enable),
        .bus_ls_type_o      (bus_ls_type),
        .bus_read_done_i    (bus_read_done),
        .bus_write_done_i   (bus_write_done),
        .bus_read_data_i    (bus_read_data)
    );

    // same-cycle instruction memory
    assign pc_off      = pc - RESET_PC;
    assign instruction = (pc_off < 64'd256 && pc_off[1:0] == 2'b00) ?
                         imem[pc_off[7:2]] : NOP_INST;   // misaligned pc fetches a nop

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rand_bits();
        return $random(seed);
    endfunction

    function automatic xlen_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand_bits();
        lo = rand_bits();
        return {hi, lo};
    endfunction

    function automatic xlen_t sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    // read data for the operand slots or a fill from the whole address
    function automatic xlen_t read_word(input xlen_t addr);
        if (addr == OPA_ADDR) return cur_a;
        if (addr == OPB_ADDR) return cur_b;
        return addr ^ {addr[31:0], addr[63:32]} ^ 64'h5A3C_96F0_0F69_C3A5;
    endfunction

    // instruction encoders
    function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input ls_type_t f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input ls_type_t f3, input reg_idx_t rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input ls_type_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input ls_type_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic inst_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // reference model
    function automatic logic signed_less(input xlen_t a, input xlen_t b);
        return (a ^ 64'h8000_0000_0000_0000) < (b ^ 64'h8000_0000_0000_0000);  // bias trick
    endfunction

    function automatic xlen_t model_alu(input ls_type_t f3, input logic alt,
                                        input xlen_t a, input xlen_t b);
        xlen_t fill;
        fill = a[63] ? ~(~64'd0 >> b[5:0]) : 64'd0;   // sign bits shifted in
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return signed_less(a, b) ? 64'd1 : 64'd0;
            3'b011:  return (a < b) ? 64'd1 : 64'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? ((a >> b[5:0]) | fill) : (a >> b[5:0]);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic model_branch(input ls_type_t f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return signed_less(a, b);
            3'b101:  return !signed_less(a, b);
            3'b110:  return a < b;
            default: return !(a < b);
        endcase
    endfunction

    function automatic xlen_t width_mask(input ls_type_t t);
        case (t[1:0])
            2'd0:    return 64'hFF;
            2'd1:    return 64'hFFFF;
            2'd2:    return 64'hFFFF_FFFF;
            default: return '1;
        endcase
    endfunction

    function automatic xlen_t model_load(input ls_type_t t, input xlen_t w);
        xlen_t m;
        xlen_t v;
        m = width_mask(t);
        v = w & m;
        if (!t[2] && ((v & ~(m >> 1)) != 64'd0)) v = v | ~m;   // top bit of field set
        return v;
    endfunction

    function automatic string kind_name(input logic [1:0] k);
        case (k)
            K_PLAIN:  return "result";
            K_STORE:  return "store";
            K_BRANCH: return "branch";
            default:  return "jump";
        endcase
    endfunction

    task automatic add_row(input logic [1:0] kind, input inst_t inst, input xlen_t a,
                           input xlen_t b, input xlen_t imm, input xlen_t exp_addr,
                           input xlen_t exp_data, input ls_type_t exp_type);
        row_t row;
        row.kind     = kind;
        row.inst     = inst;
        row.op_a     = a;
        row.op_b     = b;
        row.imm      = imm;
        row.exp_addr = exp_addr;
        row.exp_data = exp_data;
        row.exp_type = exp_type;
        rows.push_back(row);
    endtask

    task automatic build_table();
        xlen_t       a;
        xlen_t       b;
        xlen_t       imm;
        logic [31:0] r;
        ls_type_t    f3;
        logic        alt;
        logic        taken;
        for (int f = 0; f < 10; f++) begin      // reg-reg ops with sub and sra last
            f3  = (f < 8) ? ls_type_t'(f) : ((f == 8) ? F3_ADD_SUB : F3_SRL_SRA);
            alt = (f >= 8);
            a   = rand_word();
            b   = rand_word();
            add_row(K_PLAIN, enc_r(alt ? F7_ALT : F7_BASE, 5'd2, 5'd1, f3, 5'd3), a, b, '0,
                    STORE_ADDR, model_alu(f3, alt, a, b), LS_D);
        end
        for (int f = 0; f < 2; f++) begin       // -1 against 1 for signed vs unsigned
            f3 = (f == 0) ? F3_SLT : F3_SLTU;
            add_row(K_PLAIN, enc_r(F7_BASE, 5'd2, 5'd1, f3, 5'd3), '1, 64'd1, '0,
                    STORE_ADDR, model_alu(f3, 1'b0, '1, 64'd1), LS_D);
        end
        for (int f = 0; f < 9; f++) begin       // immediate forms with srai last
            f3  = (f < 8) ? ls_type_t'(f) : F3_SRL_SRA;
            alt = (f == 8);
            a   = rand_word();
            r   = rand_bits();
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) r[11:6] = alt ? 6'b010000 : 6'b000000;
            imm = sext12(r[11:0]);
            add_row(K_PLAIN, enc_i(r[11:0], 5'd1, f3, 5'd3, OPC_IMM), a, '0, imm,
                    STORE_ADDR, model_alu(f3, alt, a, imm), LS_D);
        end
        for (int t = 0; t < 7; t++) begin       // lb .. lwu
            a   = rand_word();
            r   = rand_bits();
            imm = sext12(r[11:0]);
            add_row(K_PLAIN, enc_i(r[11:0], 5'd1, ls_type_t'(t), 5'd3, OPC_LOAD), a, '0, imm,
                    STORE_ADDR, model_load(ls_type_t'(t), read_word(a + imm)), LS_D);
        end
        for (int t = 0; t < 4; t++) begin       // sb .. sd
            a   = rand_word();
            b   = rand_word();
            r   = rand_bits();
            imm = sext12(r[11:0]);
            add_row(K_STORE, enc_s(r[11:0], 5'd2, 5'd1, ls_type_t'(t)), a, b, imm,
                    a + imm, b & width_mask(ls_type_t'(t)), ls_type_t'(t));
        end
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                f3 = ls_type_t'(f);
                for (int k = 0; k < 2; k++) begin
                    if (k == 0) begin
                        a = rand_word();
                        b = a;
                    end else if (f3[1]) begin           // unsigned puts 3 below -5
                        a = 64'd3;
                        b = 64'hFFFF_FFFF_FFFF_FFFB;
                    end else begin
                        a = 64'hFFFF_FFFF_FFFF_FFFB;
                        b = 64'd3;
                    end
                    taken = model_branch(f3, a, b);
                    add_row(K_BRANCH, enc_b(13'd12, 5'd2, 5'd1, f3), a, b, 64'd12,
                            taken ? TARGET_ADDR : STORE_ADDR, taken ? b : a, LS_D);
                end
            end
        end
        // jal at slot 2 links slot 3 and lands on slot 5
        add_row(K_JUMP, enc_j(21'd12, 5'd3), '0, '0, 64'd12, TARGET_ADDR,
                RESET_PC + 64'd12, LS_D);
        r   = rand_bits();
        imm = sext12(r[11:0]);
        a   = RESET_PC + 64'd21 - imm;         // odd sum so bit 0 must drop
        add_row(K_JUMP, enc_i(r[11:0], 5'd1, 3'b000, 5'd3, OPC_JALR), a, '0, imm,
                TARGET_ADDR, RESET_PC + 64'd12, LS_D);
        r   = rand_bits();
        imm = {{32{r[19]}}, r[19:0], 12'b0};
        add_row(K_PLAIN, {r[19:0], 5'd3, OPC_LUI}, '0, '0, imm, STORE_ADDR, imm, LS_D);
        add_row(K_PLAIN, {r[19:0], 5'd3, OPC_AUIPC}, '0, '0, imm, STORE_ADDR,
                RESET_PC + 64'd8 + imm, LS_D);
        a = rand_word();                        // addi x0 then sd x0
        add_row(K_PLAIN, enc_i(12'h123, 5'd1, F3_ADD_SUB, 5'd0, OPC_IMM), a, '0, 64'h123,
                STORE_ADDR, 64'd0, LS_D);
    endtask

    // slots hold ld x1, ld x2, test, store, jal +8 and the target store
    task automatic load_program(input row_t row);
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP_INST;
        end
        imem[0] = enc_i(OPA_ADDR[11:0], 5'd0, LS_D, 5'd1, OPC_LOAD);
        imem[1] = enc_i(OPB_ADDR[11:0], 5'd0, LS_D, 5'd2, OPC_LOAD);
        imem[2] = row.inst;
        case (row.kind)
            K_STORE:  imem[3] = NOP_INST;
            K_BRANCH: imem[3] = enc_s(STORE_ADDR[11:0], 5'd1, 5'd0, LS_D);
            default:  imem[3] = enc_s(STORE_ADDR[11:0], row.inst[11:7], 5'd0, LS_D);
        endcase
        imem[4] = enc_j(21'd8, 5'd0);
        imem[5] = enc_s(TARGET_ADDR[11:0], (row.kind == K_BRANCH) ? 5'd2 : 5'd3, 5'd0, LS_D);
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
            row_ok = 1'b0;
        end
    endtask

    task automatic check_addr(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
            row_ok = 1'b0;
        end
    endtask

    task automatic check_type(input string name, input ls_type_t exp, input ls_type_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
            row_ok = 1'b0;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
            row_ok = 1'b0;
        end
    endtask

    task automatic run_row(input int idx);
        row_t row;
        row    = rows[idx];
        row_ok = 1'b1;
        @(posedge clk);
        #2;
        reset = 1'b0;
        cur_a = row.op_a;
        cur_b = row.op_b;
        load_program(row);
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_type_q.delete();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b1;
        check_addr("pc_o", RESET_PC, pc);
        repeat (2) begin                        // nothing on the bus before the first ld
            check_flag("bus_read_enable_o", 1'b0, bus_read_enable);
            check_flag("bus_write_enable_o", 1'b0, bus_write_enable);
            @(posedge clk);
            #2;
        end
        while (pc < RESET_PC + 64'd32) begin    // slot 7 fetched so all stores retired
            @(posedge clk);
            #2;
        end
        if (wr_addr_q.size() != 1) begin
            $display("test %0d: expected one bus write, saw %0d", idx, wr_addr_q.size());
            errors++;
            row_ok = 1'b0;
        end else begin
            check_addr("bus_address_o", row.exp_addr, wr_addr_q[0]);
            check_word("bus_write_data_o", row.exp_data, wr_data_q[0]);
            check_type("bus_ls_type_o", row.exp_type, wr_type_q[0]);
        end
        if (!row_ok) tests_failed++;
        $display("test %0d %s inst %h imm %h: %s", idx, kind_name(row.kind), row.inst, row.imm,
                 row_ok ? "pass" : "fail");
    endtask

    // bus responder with a random done delay of 0..3 cycles
    initial begin
        int unsigned lat;
        logic        is_read;
        bus_read_done  = 1'b0;
        bus_write_done = 1'b0;
        bus_read_data  = '0;
        forever begin
            @(posedge clk);
            #2;
            if (bus_read_enable || bus_write_enable) begin
                is_read = bus_read_enable;
                if (!is_read) begin
                    wr_addr_q.push_back(bus_address);
                    wr_data_q.push_back(bus_write_data);
                    wr_type_q.push_back(bus_ls_type);
                end
                lat = $unsigned($random(seed)) % 4;
                repeat (lat) begin
                    @(posedge clk);
                    #2;
                end
                if (is_read) begin
                    bus_read_data = read_word(bus_address);
                    bus_read_done = 1'b1;
                end else begin
                    bus_write_done = 1'b1;
                end
                @(posedge clk);
                #2;
                bus_read_done  = 1'b0;          // one-cycle done level
                bus_write_done = 1'b0;
            end
        end
    end

    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = rows.size() * 8 * 6 * CLK_PERIOD;   // rows x instr x cycles
        #(limit_ns);
        $display("timeout: the core did not finish all tests in %0d ns", limit_ns);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP_INST;
        end
        cur_a = '0;
        cur_b = '0;
        build_table();
        table_ready = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("%0d tests, %0d failed, %0d errors", rows.size(), tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
